// File: xconf_pkg.sv
package xconf_pkg;

   // opcode width, sized for the five commands with room to grow
   localparam int OP_W = 3;

   // decoded command handed from the decode stage to the execute stage
   typedef enum logic [OP_W-1:0] {
      // no command this cycle
      OP_NONE  = 3'd0,
      // replace one field of the configuration vector
      OP_FIELD = 3'd1,
      // zero the whole vector
      OP_CLEAR = 3'd2,
      // copy the vector into a snapshot slot
      OP_STORE = 3'd3,
      // copy a snapshot slot back into the vector
      OP_LOAD  = 3'd4
   } conf_op_t;

   // index width for a table of n entries, at least one bit
   function automatic int sel_w(input int n);
      int w;
      w = 1;
      while ((1 << w) < n) begin
         w = w + 1;
      end
      return w;
   endfunction

   // address map layout, low to high:
   //   0 .. n_fields-1      field writes
   //   n_fields             clear
   //   top bit set          snapshot memory, low bits pick the slot
   //   anything else        unmapped
   // smallest address width that fits the field region, the clear
   // address and the memory region above them
   function automatic int min_addr_w(input int n_fields, input int mem_slots);
      int w;
      w = 1 + sel_w(n_fields + 1);
      if (w < 1 + sel_w(mem_slots)) begin
         w = 1 + sel_w(mem_slots);
      end
      return w;
   endfunction

endpackage

// File: conf_cmd_if.sv
interface conf_cmd_if #(
   parameter int DATA_W    = 32,
   parameter int N_FIELDS  = 8,
   parameter int MEM_SLOTS = 4
);

   localparam int FIELD_W = xconf_pkg::sel_w(N_FIELDS);
   localparam int SLOT_W  = xconf_pkg::sel_w(MEM_SLOTS);

   // valid for one cycle whenever op is not OP_NONE
   xconf_pkg::conf_op_t op;
   logic [FIELD_W-1:0]  field;
   logic [SLOT_W-1:0]   slot;
   logic [DATA_W-1:0]   data;

   // decode stage drives the whole command
   modport source (
      output op, field, slot, data
   );

   // register file needs the field index and the write data
   modport reg_side (
      input op, field, data
   );

   // snapshot memory only needs the slot
   modport mem_side (
      input op, slot
   );

endinterface

// File: conf_decoder.sv
module conf_decoder #(
   parameter int DATA_W    = 32,
   parameter int N_FIELDS  = 8,
   parameter int MEM_SLOTS = 4,
   parameter int ADDR_W    = 6
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              ctr_valid,
   input  logic              ctr_we,
   input  logic [ADDR_W-1:0] ctr_addr,
   input  logic [DATA_W-1:0] ctr_data,
   output logic              unmapped_err,
   conf_cmd_if.source        cmd
);

   localparam int FIELD_W = xconf_pkg::sel_w(N_FIELDS);
   localparam int SLOT_W  = xconf_pkg::sel_w(MEM_SLOTS);
   localparam int MEM_BIT = ADDR_W - 1;
   localparam int IDX_W   = ADDR_W - 1;

   // the clear address and every slot have to fit under the top bit
   if (ADDR_W < xconf_pkg::min_addr_w(N_FIELDS, MEM_SLOTS)) begin : g_map_check
      $error("ADDR_W too narrow for the configuration address map");
   end

   logic                in_field;
   logic                in_clear;
   logic                in_mem;
   xconf_pkg::conf_op_t op_next;
   logic                err_next;

   // address regions
   always_comb begin
      in_field = (ctr_addr < ADDR_W'(N_FIELDS));
      in_clear = (ctr_addr == ADDR_W'(N_FIELDS));
      // slots past MEM_SLOTS count as unmapped
      in_mem   = ctr_addr[MEM_BIT] && (ctr_addr[IDX_W-1:0] < IDX_W'(MEM_SLOTS));
   end

   // strobe to opcode
   always_comb begin
      op_next  = xconf_pkg::OP_NONE;
      err_next = 1'b0;
      if (ctr_valid) begin
         if (in_clear) begin
            // clear ignores we
            op_next = xconf_pkg::OP_CLEAR;
         end else if (in_field) begin
            // no readback, so a field read is simply dropped
            if (ctr_we) begin
               op_next = xconf_pkg::OP_FIELD;
            end
         end else if (in_mem) begin
            op_next = ctr_we ? xconf_pkg::OP_STORE : xconf_pkg::OP_LOAD;
         end else begin
            err_next = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd.op       <= xconf_pkg::OP_NONE;
         unmapped_err <= 1'b0;
      end else begin
         cmd.op       <= op_next;
         unmapped_err <= err_next;
      end
   end

   // payload only matters while op is live
   always_ff @(posedge clk) begin
      if (ctr_valid) begin
         cmd.field <= ctr_addr[FIELD_W-1:0];
         cmd.slot  <= ctr_addr[SLOT_W-1:0];
         cmd.data  <= ctr_data;
      end
   end

endmodule

// File: conf_reg_file.sv
module conf_reg_file #(
   parameter int DATA_W   = 32,
   parameter int N_FIELDS = 8
) (
   input  logic                         clk,
   input  logic                         reset,
   conf_cmd_if.reg_side                 cmd,
   // selected snapshot from the memory
   input  logic [N_FIELDS*DATA_W-1:0]   snap,
   // configuration vector, field 0 in the low word
   output logic [N_FIELDS*DATA_W-1:0]   conf_out
);

   logic [DATA_W-1:0] fields [N_FIELDS];

   // one word per field, updated one edge after the command
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < N_FIELDS; i++) begin
            fields[i] <= '0;
         end
      end else begin
         case (cmd.op)
            xconf_pkg::OP_FIELD: begin
               // decoder only issues in-range field indices
               fields[cmd.field] <= cmd.data;
            end
            xconf_pkg::OP_CLEAR: begin
               for (int i = 0; i < N_FIELDS; i++) begin
                  fields[i] <= '0;
               end
            end
            xconf_pkg::OP_LOAD: begin
               // snap is read combinationally in this same stage
               for (int i = 0; i < N_FIELDS; i++) begin
                  fields[i] <= snap[i*DATA_W +: DATA_W];
               end
            end
            default: begin
               // store and none keep the vector as is
            end
         endcase
      end
   end

   // flatten the fields onto the vector
   for (genvar g = 0; g < N_FIELDS; g++) begin : g_pack
      assign conf_out[g*DATA_W +: DATA_W] = fields[g];
   end

endmodule

// File: conf_mem.sv
module conf_mem #(
   parameter int DATA_W    = 32,
   parameter int N_FIELDS  = 8,
   parameter int MEM_SLOTS = 4
) (
   input  logic                         clk,
   conf_cmd_if.mem_side                 cmd,
   // live configuration vector, captured on store
   input  logic [N_FIELDS*DATA_W-1:0]   conf_in,
   // addressed slot, read without a register
   output logic [N_FIELDS*DATA_W-1:0]   snap
);

   localparam int CONF_W = N_FIELDS * DATA_W;

   // snapshot storage, contents undefined until stored
   logic [CONF_W-1:0] slots [MEM_SLOTS];

   // store takes the vector as it stands before this edge, so every
   // earlier command has already landed in conf_in
   always_ff @(posedge clk) begin
      if (cmd.op == xconf_pkg::OP_STORE) begin
         slots[cmd.slot] <= conf_in;
      end
   end

   // combinational read lets a load finish in the execute stage
   assign snap = slots[cmd.slot];

endmodule

// File: xconf.sv
module xconf #(
   parameter int DATA_W    = 32,
   parameter int N_FIELDS  = 8,
   parameter int MEM_SLOTS = 4,
   parameter int ADDR_W    = 6
) (
   input  logic                         clk,
   input  logic                         reset,

   // host control bus
   input  logic                         ctr_valid,
   input  logic                         ctr_we,
   input  logic [ADDR_W-1:0]            ctr_addr,
   input  logic [DATA_W-1:0]            ctr_data,

   // configuration vector to the data engine
   output logic [N_FIELDS*DATA_W-1:0]   conf_out,
   // one-cycle pulse for a strobe outside the map
   output logic                         unmapped_err
);

   localparam int CONF_W = N_FIELDS * DATA_W;

   // memory side of the register file loop
   logic [CONF_W-1:0] snap;

   // registered command between the two stages
   conf_cmd_if #(
      .DATA_W    (DATA_W),
      .N_FIELDS  (N_FIELDS),
      .MEM_SLOTS (MEM_SLOTS)
   ) cmd_bus ();

   conf_decoder #(
      .DATA_W    (DATA_W),
      .N_FIELDS  (N_FIELDS),
      .MEM_SLOTS (MEM_SLOTS),
      .ADDR_W    (ADDR_W)
   ) u_decoder (
      .clk          (clk),
      .reset        (reset),
      .ctr_valid    (ctr_valid),
      .ctr_we       (ctr_we),
      .ctr_addr     (ctr_addr),
      .ctr_data     (ctr_data),
      .unmapped_err (unmapped_err),
      .cmd          (cmd_bus.source)
   );

   // execute stage, both halves act on the same edge
   conf_reg_file #(
      .DATA_W   (DATA_W),
      .N_FIELDS (N_FIELDS)
   ) u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .cmd      (cmd_bus.reg_side),
      .snap     (snap),
      .conf_out (conf_out)
   );

   conf_mem #(
      .DATA_W    (DATA_W),
      .N_FIELDS  (N_FIELDS),
      .MEM_SLOTS (MEM_SLOTS)
   ) u_mem (
      .clk     (clk),
      .cmd     (cmd_bus.mem_side),
      .conf_in (conf_out),
      .snap    (snap)
   );

endmodule

// File: xconf_props.sv
module xconf_props #(
   parameter int N_FIELDS = 8,
   parameter int FIELD_W  = 3
) (
   input logic                clk,
   input logic                reset,
   input xconf_pkg::conf_op_t op,
   input logic [FIELD_W-1:0]  field,
   input logic                unmapped_err
);

   timeunit 1ns;
   timeprecision 1ps;

   // field writes stay inside the vector
   field_in_range: assert property (
      @(posedge clk) disable iff (reset)
      (op == xconf_pkg::OP_FIELD) |-> (int'(field) < N_FIELDS)
   ) else $error("field write with index %0d past the last field", field);

   // a strobe is either a command or an error, never both
   err_excludes_cmd: assert property (
      @(posedge clk) disable iff (reset)
      !(unmapped_err && (op != xconf_pkg::OP_NONE))
   ) else $error("unmapped_err raised together with a live command");

   // pipeline comes out of reset idle
   idle_after_reset: assert property (
      @(posedge clk) reset |=> (op == xconf_pkg::OP_NONE) && !unmapped_err
   ) else $error("command pipeline not idle after reset");

endmodule

// File: xconf_checker.sv
module xconf_checker #(
   parameter int CONF_W = 256
) (
   input  logic              clk,
   input  logic              check_en,
   input  logic              finished,
   input  int                test_id,
   input  logic [CONF_W-1:0] conf_out,
   input  logic              unmapped_err,
   input  logic [CONF_W-1:0] exp_conf,
   input  logic              exp_err,
   output int                error_count,
   output logic              report_done
);

   timeunit 1ns;
   timeprecision 1ps;

   int   cur_id       = 0;
   int   test_cycles  = 0;
   int   test_errors  = 0;
   int   total_cycles = 0;
   int   errors       = 0;
   int   tests_run    = 0;
   int   tests_failed = 0;
   logic done         = 1'b0;

   assign error_count = errors;
   assign report_done = done;

   function automatic string test_name(input int id);
      case (id)
         0: return "reset_state";
         1: return "field_writes";
         2: return "clear";
         3: return "store_load";
         4: return "unmapped";
         5: return "random_mix";
         default: return "unknown";
      endcase
   endfunction

   task automatic close_test();
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("test %s: %s, %0d cycles checked, %0d errors", test_name(cur_id),
               (test_errors == 0) ? "pass" : "FAIL", test_cycles, test_errors);
      test_cycles = 0;
      test_errors = 0;
   endtask

   // outputs settle after the rising edge, so compare on the falling one
   always @(negedge clk) begin
      if (check_en && !done) begin
         if (test_id != cur_id) begin
            close_test();
            cur_id = test_id;
         end
         if (finished) begin
            close_test();
            $display("tests run %0d, failed %0d, cycles checked %0d, errors %0d",
                     tests_run, tests_failed, total_cycles, errors);
            done = 1'b1;
         end else begin
            test_cycles++;
            total_cycles++;
            if (conf_out !== exp_conf) begin
               $display("** Error %s: conf_out expected %h actual %h",
                        test_name(cur_id), exp_conf, conf_out);
               test_errors++;
               errors++;
            end
            if (unmapped_err !== exp_err) begin
               $display("** Error %s: unmapped_err expected %b actual %b",
                        test_name(cur_id), exp_err, unmapped_err);
               test_errors++;
               errors++;
            end
         end
      end
   end

endmodule

// File: xconf_tb.sv
module xconf_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int DATA_W    = 32;
   localparam int N_FIELDS  = 8;
   localparam int MEM_SLOTS = 4;
   localparam int ADDR_W    = 6;
   localparam int CONF_W    = N_FIELDS * DATA_W;

   // bus cycles per test before its short drain
   localparam int T_RESET = 4;
   localparam int T_FIELD = 64;
   localparam int T_CLEAR = 8 * 5;
   localparam int T_STORE = 6 * 9;
   localparam int T_UNMAP = 4 + 32;
   localparam int T_MIX   = 300;
   localparam int DRAIN   = 2;
   localparam int CYCLE_LIMIT = 3 + T_RESET + T_FIELD + T_CLEAR + T_STORE + T_UNMAP
                                + T_MIX + 6 * DRAIN + 20;

   logic              clk;
   logic              reset;
   logic              ctr_valid;
   logic              ctr_we;
   logic [ADDR_W-1:0] ctr_addr;
   logic [DATA_W-1:0] ctr_data;
   logic [CONF_W-1:0] conf_out;
   logic              unmapped_err;
   logic              check_en;
   logic              finished;
   int                test_id;
   logic [CONF_W-1:0] exp_conf;
   logic              exp_err;
   int                error_count;
   logic              report_done;
   logic [31:0]       rng;
   int                cycles = 0;

   // reference model state
   logic [CONF_W-1:0] model_conf;
   logic [CONF_W-1:0] model_snap [MEM_SLOTS];
   logic              model_stored [MEM_SLOTS];
   // outcomes still in the pipeline with the oldest at the front
   logic [CONF_W-1:0] conf_q [$];
   logic              err_q [$];

   bind conf_decoder xconf_props #(
      .N_FIELDS (N_FIELDS),
      .FIELD_W  (FIELD_W)
   ) props (
      .clk          (clk),
      .reset        (reset),
      .op           (cmd.op),
      .field        (cmd.field),
      .unmapped_err (unmapped_err)
   );

   xconf #(
      .DATA_W    (DATA_W),
      .N_FIELDS  (N_FIELDS),
      .MEM_SLOTS (MEM_SLOTS),
      .ADDR_W    (ADDR_W)
   ) uut (
      .clk          (clk),
      .reset        (reset),
      .ctr_valid    (ctr_valid),
      .ctr_we       (ctr_we),
      .ctr_addr     (ctr_addr),
      .ctr_data     (ctr_data),
      .conf_out     (conf_out),
      .unmapped_err (unmapped_err)
   );

   xconf_checker #(
      .CONF_W (CONF_W)
   ) u_check (
      .clk          (clk),
      .check_en     (check_en),
      .finished     (finished),
      .test_id      (test_id),
      .conf_out     (conf_out),
      .unmapped_err (unmapped_err),
      .exp_conf     (exp_conf),
      .exp_err      (exp_err),
      .error_count  (error_count),
      .report_done  (report_done)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic logic [ADDR_W-1:0] field_addr(input logic [31:0] r);
      return ADDR_W'(r % N_FIELDS);
   endfunction

   function automatic logic [ADDR_W-1:0] mem_addr(input int slot);
      return {1'b1, (ADDR_W-1)'(slot)};
   endfunction

   function automatic logic [ADDR_W-1:0] unmapped_addr(input logic [31:0] r);
      int top;
      int a;
      top = 1 << (ADDR_W - 1);
      // either the gap above the clear address or a missing slot in the memory region
      if (r[20]) begin
         a = N_FIELDS + 1 + int'(r % (top - N_FIELDS - 1));
      end else begin
         a = top + MEM_SLOTS + int'(r % (top - MEM_SLOTS));
      end
      return ADDR_W'(a);
   endfunction

   task automatic apply_model(input logic valid, input logic we, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, output logic err);
      int a;
      int low;
      a   = int'(addr);
      low = int'(addr[ADDR_W-2:0]);
      err = 1'b0;
      if (valid) begin
         if (a == N_FIELDS) begin
            model_conf = '0;
         end else if (a < N_FIELDS) begin
            // field reads do nothing without readback
            if (we) begin
               model_conf[a*DATA_W +: DATA_W] = data;
            end
         end else if (addr[ADDR_W-1] && low < MEM_SLOTS) begin
            if (we) begin
               model_snap[low]   = model_conf;
               model_stored[low] = 1'b1;
            end else begin
               model_conf = model_snap[low];
            end
         end else begin
            err = 1'b1;
         end
      end
   endtask

   // one bus cycle whose outcome falls due two edges later
   task automatic step(input logic valid, input logic we, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data);
      logic err;
      ctr_valid = valid;
      ctr_we    = we;
      ctr_addr  = addr;
      ctr_data  = data;
      exp_conf  = conf_q[0];
      exp_err   = err_q[1];
      void'(conf_q.pop_front());
      void'(err_q.pop_front());
      apply_model(valid, we, addr, data, err);
      conf_q.push_back(model_conf);
      err_q.push_back(err);
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         step(1'b0, 1'b0, '0, '0);
      end
   endtask

   task automatic write_fields();
      test_id = 1;
      for (int i = 0; i < T_FIELD; i++) begin
         step(1'b1, 1'b1, field_addr(next_rand()), next_rand());
      end
      idle(DRAIN);
   endtask

   task automatic clear_vector();
      logic [31:0] r;
      test_id = 2;
      for (int i = 0; i < 8; i++) begin
         for (int j = 0; j < 4; j++) begin
            step(1'b1, 1'b1, field_addr(next_rand()), next_rand());
         end
         r = next_rand();
         step(1'b1, r[4], ADDR_W'(N_FIELDS), next_rand());
      end
      idle(DRAIN);
   endtask

   task automatic store_then_load();
      int s;
      test_id = 3;
      for (int i = 0; i < 6; i++) begin
         s = int'(next_rand() % MEM_SLOTS);
         // store right behind a field write
         step(1'b1, 1'b1, field_addr(next_rand()), next_rand());
         step(1'b1, 1'b1, mem_addr(s), next_rand());
         for (int j = 0; j < 6; j++) begin
            step(1'b1, 1'b1, field_addr(next_rand()), next_rand());
         end
         step(1'b1, 1'b0, mem_addr(s), next_rand());
      end
      idle(DRAIN);
   endtask

   task automatic strobe_unmapped();
      logic [31:0] r;
      test_id = 4;
      for (int i = 0; i < 4; i++) begin
         step(1'b1, 1'b1, field_addr(next_rand()), next_rand());
      end
      for (int i = 0; i < 32; i++) begin
         r = next_rand();
         if (i % 2 == 0) begin
            step(1'b1, r[4], unmapped_addr(next_rand()), next_rand());
         end else begin
            step(1'b1, 1'b0, field_addr(next_rand()), next_rand());
         end
      end
      idle(DRAIN);
   endtask

   task automatic mix_commands();
      logic [31:0] r;
      int kind;
      int s;
      test_id = 5;
      for (int i = 0; i < T_MIX; i++) begin
         r    = next_rand();
         kind = int'(r[3:0]);
         s    = int'((r >> 8) % MEM_SLOTS);
         if (kind < 4) begin
            // idle with noise on the address and data lines
            step(1'b0, r[4], ADDR_W'(r >> 16), next_rand());
         end else if (kind < 10) begin
            step(1'b1, 1'b1, field_addr(next_rand()), next_rand());
         end else if (kind == 10) begin
            step(1'b1, r[4], ADDR_W'(N_FIELDS), next_rand());
         end else if (kind < 13 || (kind == 13 && !model_stored[s])) begin
            step(1'b1, 1'b1, mem_addr(s), next_rand());
         end else if (kind == 13) begin
            step(1'b1, 1'b0, mem_addr(s), next_rand());
         end else if (kind == 14) begin
            step(1'b1, r[4], unmapped_addr(next_rand()), next_rand());
         end else begin
            step(1'b1, 1'b0, field_addr(next_rand()), next_rand());
         end
      end
      idle(DRAIN);
   endtask

   initial begin
      reset      = 1'b1;
      ctr_valid  = 1'b0;
      ctr_we     = 1'b0;
      ctr_addr   = '0;
      ctr_data   = '0;
      check_en   = 1'b0;
      finished   = 1'b0;
      test_id    = 0;
      exp_conf   = '0;
      exp_err    = 1'b0;
      rng        = 32'h36c1;
      model_conf = '0;
      for (int i = 0; i < MEM_SLOTS; i++) begin
         model_stored[i] = 1'b0;
      end
      // the reset cycles stand in for the two commands in flight
      repeat (2) begin
         conf_q.push_back('0);
         err_q.push_back(1'b0);
      end
      repeat (3) begin
         @(posedge clk);
      end
      #1;
      reset    = 1'b0;
      check_en = 1'b1;
      test_id  = 0;
      idle(T_RESET + DRAIN);
      write_fields();
      clear_vector();
      store_then_load();
      strobe_unmapped();
      mix_commands();
      finished = 1'b1;
      while (!report_done) begin
         @(negedge clk);
      end
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: verilog.f
xconf_pkg.sv
conf_cmd_if.sv
conf_decoder.sv
conf_reg_file.sv
conf_mem.sv
xconf.sv
xconf_props.sv
xconf_checker.sv
xconf_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, then pass only if the pass line shows up in the output
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module xconf_tb -f verilog.f \
   && ./obj_dir/Vxconf_tb | tee /dev/stderr | grep -q "Simulation PASSED" \
   || { echo "xconf run failed" >&2; exit 1; }
